//--- controlUnit.f
+incdir+tests
hw/isaPkg.sv
hw/controlPkg.sv
hw/instructionDecoder.sv
hw/memoryWaitTimer.sv
hw/controlSequencer.sv
hw/controlOutputs.sv
hw/controlUnit.sv
tests/controlUnitTb.sv

//--- Bender.yml
package:
  name: controlUnit

sources:
  - files:
      - hw/isaPkg.sv
      - hw/controlPkg.sv
      - hw/instructionDecoder.sv
      - hw/memoryWaitTimer.sv
      - hw/controlSequencer.sv
      - hw/controlOutputs.sv
      - hw/controlUnit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/controlUnitTb.sv

//--- tests/controlUnitModel.svh
`ifndef CONTROL_UNIT_MODEL_SVH
`define CONTROL_UNIT_MODEL_SVH

// pcWrite is the MSB when written as an 8-bit literal
typedef struct packed {
	logic pcWrite;
	logic regWrite;
	logic irWrite;
	logic writeRegA;
	logic writeRegB;
	logic aluOutControl;
	logic shiftSrc;
	logic shiftAmt;
} strobeWord_t;

typedef struct packed {
	aluSrcA_t aluSrcA;
	aluSrcB_t aluSrcB;
	aluOp_t aluOp;
	pcSource_t pcSource;
	shiftCtrl_t shiftCtrl;
	regDst_t regDst;
	memToReg_t memToReg;
} fieldWord_t;

typedef struct packed {
	strobeWord_t strobes;
	fieldWord_t fields;
} controlWord_t;

function automatic controlState_t modelNextState(controlState_t st, instrClass_t cls,
	logic waitOver);
	case (st)
		stateFetch: return stateFetchWait;
		stateFetchWait: return waitOver ? stateFetchLoad : stateFetchWait;
		stateFetchLoad: return stateDecode;
		stateDecode: return stateExecute;
		stateExecute: begin
			case (cls)
				classAddi: return stateAfterAddi;
				classAddiu: return stateAfterAddiu;
				classAdd, classAnd, classSub: return stateAfterAluOp;
				classSrl, classSra: return stateAfterShift;
				classXchg: return stateAfterXchg;
				classBreak: return stateFetch;
				default: return stateIdle;
			endcase
		end
		stateIdle: return stateFetch;
		// All writeback states
		default: return stateIdle;
	endcase
endfunction

// Word expected one cycle after the state st
function automatic controlWord_t modelWord(controlState_t st, instrClass_t cls);
	controlWord_t word;
	word = '0;
	case (st)
		stateFetch: begin
			word.strobes = 8'b1000_0000;
			word.fields = '{2'b00, 3'b001, aluAdd, 3'b001, 3'b000, 3'b101, 4'b0000};
		end
		stateFetchLoad: word.strobes = 8'b0010_0000;
		stateDecode: begin
			word.strobes = 8'b0011_1110;
			word.fields = '{2'b00, 3'b100, aluAdd, 3'b000, shiftLoad, 3'b000, 4'b0000};
		end
		stateExecute: begin
			case (cls)
				classAddi, classAddiu: begin
					word.strobes = 8'b0000_0100;
					word.fields = '{2'b10, 3'b010, aluAdd, 3'b000, 3'b000, 3'b000, 4'b0000};
					if (cls == classAddi) begin
						word.fields.regDst = 3'b010;
					end
				end
				classAdd, classAnd, classSub: begin
					word.strobes = 8'b0000_0100;
					word.fields.aluSrcA = 2'b10;
					word.fields.aluOp = (cls == classAdd) ? aluAdd :
						((cls == classSub) ? aluSub : aluAnd);
				end
				classSrl, classSra: begin
					word.strobes = 8'b0000_0001;
					word.fields.shiftCtrl = (cls == classSrl) ? shiftRight : shiftArith;
				end
				classLui: begin
					word.strobes = 8'b0100_0000;
					word.fields.regDst = 3'b010;
					word.fields.memToReg = 4'b1010;
				end
				classBreak: begin
					word.strobes = 8'b1000_0000;
					word.fields = '{2'b00, 3'b001, aluSub, 3'b001, 3'b000, 3'b000, 4'b0000};
				end
				default: ;
			endcase
		end
		stateAfterAddi, stateAfterAddiu: begin
			word.strobes.regWrite = 1'b1;
			word.fields.regDst = 3'b010;
			word.fields.memToReg = 4'b1000;
		end
		stateAfterAluOp, stateAfterShift, stateAfterXchg: begin
			word.strobes.regWrite = 1'b1;
			word.fields.regDst = 3'b101;
			if (st == stateAfterAluOp) begin
				word.fields.memToReg = 4'b1000;
			end else if (st == stateAfterShift) begin
				word.fields.memToReg = 4'b0011;
			end
		end
		default: ;
	endcase
	return word;
endfunction

`endif

//--- tests/controlUnitTb.sv
`timescale 1ns/10ps

module controlUnitTb import isaPkg::*, controlPkg::*;;

	`include "controlUnitModel.svh"

	localparam int Latency = 2;
	localparam int ResetCycles = 5;
	localparam int DirectedCount = 12;
	localparam int RandomCount = 400;
	localparam int InstructionCount = DirectedCount + RandomCount;

	// Kinds 0 to 9 are the kept instructions, 10 and 11 the unsupported ones
	localparam opcode_t KeptOpcodes [10] = '{opcodeAddi, opcodeAddiu, opcodeLui,
		opcodeRInstruction, opcodeRInstruction, opcodeRInstruction, opcodeRInstruction,
		opcodeRInstruction, opcodeRInstruction, opcodeRInstruction};
	localparam funct_t KeptFuncts [10] = '{6'b000000, 6'b000000, 6'b000000,
		functAdd, functAnd, functSub, functSrl, functSra, functXchg, functBreak};
	localparam instrClass_t KeptClasses [10] = '{classAddi, classAddiu, classLui,
		classAdd, classAnd, classSub, classSrl, classSra, classXchg, classBreak};

	logic clock;
	logic reset;
	opcode_t opcode;
	funct_t funct;
	controlState_t state;
	logic pcWrite;
	logic regWrite;
	logic irWrite;
	logic writeRegA;
	logic writeRegB;
	logic aluOutControl;
	logic shiftSrc;
	logic shiftAmt;
	aluSrcA_t aluSrcA;
	aluSrcB_t aluSrcB;
	aluOp_t aluOp;
	pcSource_t pcSource;
	shiftCtrl_t shiftCtrl;
	regDst_t regDst;
	memToReg_t memToReg;

	// Class of the instruction on opcode and funct, as the stimulus meant it
	instrClass_t currentClass;
	string testName;

	controlUnit i_controlUnit (.*);

	initial begin : clockGen
		clock = 1'b0;
		forever begin
			#5 clock = ~clock;
		end
	end

	task automatic abortRun();
		$display("Finished with errors");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic compareState(string name, controlState_t expected, controlState_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: state expected %s, actual %s (%b)", name, expected.name(),
				actual.name(), actual);
			abortRun();
		end
	endtask

	task automatic compareBit(string name, string signal, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: %s expected %b, actual %b", name, signal, expected, actual);
			abortRun();
		end
	endtask

	task automatic compareWord(string name, fieldWord_t expected, aluSrcA_t srcA,
		aluSrcB_t srcB, aluOp_t op, pcSource_t pcSel, shiftCtrl_t shift, regDst_t dst,
		memToReg_t toReg);
		fieldWord_t actual;
		actual = '{srcA, srcB, op, pcSel, shift, dst, toReg};
		if (actual !== expected) begin
			$display("[ERROR] %s: fields expected %p, actual %p", name, expected, actual);
			abortRun();
		end
	endtask

	task automatic waitForFetch();
		do begin
			@(posedge clock);
		end while (state !== stateFetch);
	endtask

	task automatic pickInstruction(input int kind, output opcode_t op, output funct_t fn,
		output instrClass_t cls);
		fn = funct_t'($urandom);
		cls = classUnsupported;
		if (kind < 10) begin
			op = KeptOpcodes[kind];
			cls = KeptClasses[kind];
			if (op == opcodeRInstruction) begin
				fn = KeptFuncts[kind];
			end
		end else if (kind == 10) begin
			do begin
				op = opcode_t'($urandom);
			end while (op inside {opcodeRInstruction, opcodeAddi, opcodeAddiu, opcodeLui});
		end else begin
			op = opcodeRInstruction;
			while (fn inside {functAdd, functAnd, functSub, functSrl, functSra, functXchg,
				functBreak}) begin
				fn = funct_t'($urandom);
			end
		end
	endtask

	// Drive on the edge that leaves fetch so the fields hold through execute
	task automatic issueInstruction(int kind);
		opcode_t op;
		funct_t fn;
		instrClass_t cls;
		pickInstruction(kind, op, fn, cls);
		waitForFetch();
		opcode <= op;
		funct <= fn;
		currentClass <= cls;
	endtask

	initial begin : stimulus
		void'($urandom(32'ha449_f1d1));
		testName = "reset";
		reset = 1'b1;
		opcode = '0;
		funct = '0;
		currentClass = classUnsupported;
		repeat (ResetCycles) @(posedge clock);
		reset <= 1'b0;
		for (int kind = 0; kind < DirectedCount; kind++) begin
			testName = $sformatf("directed kind %0d", kind);
			issueInstruction(kind);
		end
		testName = "random stream";
		repeat (RandomCount) begin
			issueInstruction($urandom_range(11));
		end
		waitForFetch();
		repeat (2) @(posedge clock);
		$display("Finished with no errors");
		$finish;
	end

	initial begin : checkCycles
		controlState_t expState;
		controlState_t nextExp;
		controlWord_t expWord;
		int waitElapsed;
		expState = stateFetch;
		expWord = '0;
		waitElapsed = 1;
		forever begin
			@(posedge clock);
			if (reset) begin
				expState = stateFetch;
				expWord = '0;
			end else begin
				expWord = modelWord(expState, currentClass);
				nextExp = modelNextState(expState, currentClass, waitElapsed >= Latency - 1);
				if (expState == stateFetchWait && nextExp == stateFetchWait) begin
					waitElapsed++;
				end else begin
					waitElapsed = 1;
				end
				expState = nextExp;
			end
			@(negedge clock);
			compareState(testName, expState, state);
			compareBit(testName, "pcWrite", expWord.strobes.pcWrite, pcWrite);
			compareBit(testName, "regWrite", expWord.strobes.regWrite, regWrite);
			compareBit(testName, "irWrite", expWord.strobes.irWrite, irWrite);
			compareBit(testName, "writeRegA", expWord.strobes.writeRegA, writeRegA);
			compareBit(testName, "writeRegB", expWord.strobes.writeRegB, writeRegB);
			compareBit(testName, "aluOutControl", expWord.strobes.aluOutControl, aluOutControl);
			compareBit(testName, "shiftSrc", expWord.strobes.shiftSrc, shiftSrc);
			compareBit(testName, "shiftAmt", expWord.strobes.shiftAmt, shiftAmt);
			compareWord(testName, expWord.fields, aluSrcA, aluSrcB, aluOp, pcSource, shiftCtrl,
				regDst, memToReg);
		end
	end

	// Longest instruction is 7 cycles at the default latency
	initial begin : watchdog
		repeat (InstructionCount * 8 + ResetCycles + 20) @(posedge clock);
		$display("Watchdog expired, the instruction stream did not finish in time");
		abortRun();
	end

endmodule

//--- hw/controlUnit.sv
`timescale 1ns/10ps

module controlUnit import isaPkg::*, controlPkg::*; #(
	parameter waitCount_t MemoryLatency = 4'd2
) (
	input logic clock,
	input logic reset,
	input opcode_t opcode,
	input funct_t funct,
	output controlState_t state,
	output logic pcWrite,
	output logic regWrite,
	output logic irWrite,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutControl,
	output logic shiftSrc,
	output logic shiftAmt,
	output aluSrcA_t aluSrcA,
	output aluSrcB_t aluSrcB,
	output aluOp_t aluOp,
	output pcSource_t pcSource,
	output shiftCtrl_t shiftCtrl,
	output regDst_t regDst,
	output memToReg_t memToReg
);

	instrClass_t instrClass;
	logic waitStart;
	logic waitDone;

	instructionDecoder i_instructionDecoder (
		.opcode(opcode),
		.funct(funct),
		.instrClass(instrClass)
	);

	memoryWaitTimer #(
		.MemoryLatency(MemoryLatency)
	) i_memoryWaitTimer (
		.clock(clock),
		.reset(reset),
		.waitStart(waitStart),
		.waitDone(waitDone)
	);

	controlSequencer #(
		.MemoryLatency(MemoryLatency)
	) i_controlSequencer (
		.clock(clock),
		.reset(reset),
		.instrClass(instrClass),
		.waitDone(waitDone),
		.waitStart(waitStart),
		.state(state)
	);

	controlOutputs i_controlOutputs (
		.clock(clock),
		.reset(reset),
		.state(state),
		.instrClass(instrClass),
		.pcWrite(pcWrite),
		.regWrite(regWrite),
		.irWrite(irWrite),
		.writeRegA(writeRegA),
		.writeRegB(writeRegB),
		.aluOutControl(aluOutControl),
		.shiftSrc(shiftSrc),
		.shiftAmt(shiftAmt),
		.aluSrcA(aluSrcA),
		.aluSrcB(aluSrcB),
		.aluOp(aluOp),
		.pcSource(pcSource),
		.shiftCtrl(shiftCtrl),
		.regDst(regDst),
		.memToReg(memToReg)
	);

endmodule

//--- hw/controlOutputs.sv
`timescale 1ns/10ps

module controlOutputs import isaPkg::*, controlPkg::*; (
	input logic clock,
	input logic reset,
	input controlState_t state,
	input instrClass_t instrClass,
	output logic pcWrite,
	output logic regWrite,
	output logic irWrite,
	output logic writeRegA,
	output logic writeRegB,
	output logic aluOutControl,
	output logic shiftSrc,
	output logic shiftAmt,
	output aluSrcA_t aluSrcA,
	output aluSrcB_t aluSrcB,
	output aluOp_t aluOp,
	output pcSource_t pcSource,
	output shiftCtrl_t shiftCtrl,
	output regDst_t regDst,
	output memToReg_t memToReg
);

	always_ff @(posedge clock) begin
		// All-inactive word, which is also what reset leaves
		pcWrite <= 1'b0;
		regWrite <= 1'b0;
		irWrite <= 1'b0;
		writeRegA <= 1'b0;
		writeRegB <= 1'b0;
		aluOutControl <= 1'b0;
		shiftSrc <= 1'b0;
		shiftAmt <= 1'b0;
		aluSrcA <= 2'b00;
		aluSrcB <= 3'b000;
		aluOp <= 3'b000;
		pcSource <= 3'b000;
		shiftCtrl <= 3'b000;
		regDst <= 3'b000;
		memToReg <= 4'b0000;
		if (!reset) begin
			case (state)
				stateFetch: begin
					// PC + 4
					pcWrite <= 1'b1;
					aluSrcB <= 3'b001;
					aluOp <= aluAdd;
					pcSource <= 3'b001;
					regDst <= 3'b101;
				end
				stateFetchLoad: begin
					irWrite <= 1'b1;
				end
				stateDecode: begin
					irWrite <= 1'b1;
					writeRegA <= 1'b1;
					writeRegB <= 1'b1;
					aluOutControl <= 1'b1;
					shiftSrc <= 1'b1;
					aluSrcB <= 3'b100;
					aluOp <= aluAdd;
					shiftCtrl <= shiftLoad;
				end
				stateExecute: begin
					case (instrClass)
						classAddi, classAddiu: begin
							aluSrcA <= 2'b10;
							aluSrcB <= 3'b010;
							aluOp <= aluAdd;
							aluOutControl <= 1'b1;
							regDst <= (instrClass == classAddi) ? 3'b010 : 3'b000;
						end
						classAdd, classSub, classAnd: begin
							aluSrcA <= 2'b10;
							aluOutControl <= 1'b1;
							if (instrClass == classAdd) begin
								aluOp <= aluAdd;
							end else if (instrClass == classSub) begin
								aluOp <= aluSub;
							end else begin
								aluOp <= aluAnd;
							end
						end
						classSrl, classSra: begin
							shiftAmt <= 1'b1;
							shiftCtrl <= (instrClass == classSrl) ? shiftRight : shiftArith;
						end
						classLui: begin
							regWrite <= 1'b1;
							regDst <= 3'b010;
							memToReg <= 4'b1010;
						end
						classBreak: begin
							// Like fetch, but steps the PC back
							pcWrite <= 1'b1;
							aluSrcB <= 3'b001;
							aluOp <= aluSub;
							pcSource <= 3'b001;
						end
						// XCHG and unsupported keep the idle word
						default: ;
					endcase
				end
				stateAfterAddi, stateAfterAddiu: begin
					regWrite <= 1'b1;
					regDst <= 3'b010;
					memToReg <= 4'b1000;
				end
				stateAfterAluOp: begin
					regWrite <= 1'b1;
					regDst <= 3'b101;
					memToReg <= 4'b1000;
				end
				stateAfterShift: begin
					regWrite <= 1'b1;
					regDst <= 3'b101;
					memToReg <= 4'b0011;
				end
				stateAfterXchg: begin
					regWrite <= 1'b1;
					regDst <= 3'b101;
				end
				stateFetchWait, stateIdle: ;
				default: ;
			endcase
		end
	end

	// Every register write is followed by a write-free slot
	assert property (@(posedge clock) disable iff (reset) regWrite |=> !regWrite)
		else $error("regWrite high in two consecutive cycles");

endmodule

//--- hw/controlSequencer.sv
`timescale 1ns/10ps

module controlSequencer import isaPkg::*, controlPkg::*; #(
	parameter waitCount_t MemoryLatency = 4'd2
) (
	input logic clock,
	input logic reset,
	input instrClass_t instrClass,
	input logic waitDone,
	output logic waitStart,
	output controlState_t state
);

	controlState_t nextState;

	// A latency below two leaves no wait state to count
	if (MemoryLatency < 4'd2) begin : latencyCheck
		$error("MemoryLatency must be between 2 and 15");
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= stateFetch;
		end else begin
			state <= nextState;
		end
	end

	always_comb begin
		nextState = stateFetch;
		case (state)
			stateFetch: nextState = stateFetchWait;
			stateFetchWait: nextState = waitDone ? stateFetchLoad : stateFetchWait;
			stateFetchLoad: nextState = stateDecode;
			stateDecode: nextState = stateExecute;
			stateExecute: begin
				case (instrClass)
					classAddi: nextState = stateAfterAddi;
					classAddiu: nextState = stateAfterAddiu;
					classAdd, classAnd, classSub: nextState = stateAfterAluOp;
					classSrl, classSra: nextState = stateAfterShift;
					classXchg: nextState = stateAfterXchg;
					// Break restarts the fetch right away
					classBreak: nextState = stateFetch;
					// LUI and unsupported encodings
					default: nextState = stateIdle;
				endcase
			end
			stateAfterAddi, stateAfterAddiu, stateAfterAluOp, stateAfterShift,
			stateAfterXchg: begin
				nextState = stateIdle;
			end
			stateIdle: nextState = stateFetch;
			default: nextState = stateFetch;
		endcase
	end

	// Timer loads on the edge that leaves fetch
	assign waitStart = (state == stateFetch);

	assert property (@(posedge clock) disable iff (reset)
		state == stateIdle |=> state == stateFetch)
		else $error("Idle slot not followed by fetch");

	assert property (@(posedge clock) disable iff (reset)
		state inside {stateFetch, stateFetchWait, stateFetchLoad, stateDecode, stateExecute,
			stateAfterAddi, stateAfterAddiu, stateAfterAluOp, stateAfterShift,
			stateAfterXchg, stateIdle})
		else $error("Illegal state code %b", state);

endmodule

//--- hw/memoryWaitTimer.sv
`timescale 1ns/10ps

module memoryWaitTimer import controlPkg::*; #(
	parameter waitCount_t MemoryLatency = 4'd2
) (
	input logic clock,
	input logic reset,
	input logic waitStart,
	output logic waitDone
);

	localparam waitCount_t LastCount = MemoryLatency - 4'd1;

	// Zero while no fetch is outstanding
	waitCount_t count;

	always_ff @(posedge clock) begin
		if (reset) begin
			count <= '0;
		end else if (waitStart) begin
			count <= 4'd1;
		end else if (count == LastCount) begin
			count <= '0;
		end else if (count != '0) begin
			count <= count + 4'd1;
		end
	end

	assign waitDone = (count == LastCount);

	// Sequencer must not start a new fetch before the last one finished
	assert property (@(posedge clock) disable iff (reset) waitStart |-> count == '0)
		else $error("Fetch started while a memory wait was in progress");

endmodule

//--- hw/instructionDecoder.sv
`timescale 1ns/10ps

module instructionDecoder import isaPkg::*; (
	input opcode_t opcode,
	input funct_t funct,
	output instrClass_t instrClass
);

	always_comb begin
		instrClass = classUnsupported;
		case (opcode)
			opcodeAddi: begin
				instrClass = classAddi;
			end
			opcodeAddiu: begin
				instrClass = classAddiu;
			end
			opcodeLui: begin
				instrClass = classLui;
			end
			opcodeRInstruction: begin
				// R-type, class comes from the function field
				case (funct)
					functAdd: begin
						instrClass = classAdd;
					end
					functAnd: begin
						instrClass = classAnd;
					end
					functSub: begin
						instrClass = classSub;
					end
					functSrl: begin
						instrClass = classSrl;
					end
					functSra: begin
						instrClass = classSra;
					end
					functXchg: begin
						instrClass = classXchg;
					end
					functBreak: begin
						instrClass = classBreak;
					end
					default: begin
						instrClass = classUnsupported;
					end
				endcase
			end
			default: begin
				instrClass = classUnsupported;
			end
		endcase
	end

endmodule

//--- hw/controlPkg.sv
package controlPkg;

	// Idle keeps the all-ones code
	typedef enum logic [6:0] {
		stateFetch = 7'b0000000,
		stateFetchWait = 7'b0000001,
		stateFetchLoad = 7'b0000010,
		stateDecode = 7'b0000011,
		stateExecute = 7'b0000100,
		stateAfterAddiu = 7'b0000101,
		stateAfterAddi = 7'b0000110,
		stateAfterAluOp = 7'b0000111,
		stateAfterShift = 7'b0001000,
		stateAfterXchg = 7'b0001001,
		stateIdle = 7'b1111111
	} controlState_t;

	// Datapath selects
	typedef logic [1:0] aluSrcA_t;
	typedef logic [2:0] aluSrcB_t;
	typedef logic [2:0] pcSource_t;
	typedef logic [2:0] regDst_t;
	typedef logic [3:0] memToReg_t;

	typedef logic [2:0] aluOp_t;

	localparam aluOp_t aluAdd = 3'b001;
	localparam aluOp_t aluSub = 3'b010;
	localparam aluOp_t aluAnd = 3'b011;

	typedef logic [2:0] shiftCtrl_t;

	localparam shiftCtrl_t shiftLoad = 3'b001;
	localparam shiftCtrl_t shiftRight = 3'b011;
	localparam shiftCtrl_t shiftArith = 3'b100;

	// Memory wait count, also bounds the latency parameter
	typedef logic [3:0] waitCount_t;

endpackage

//--- hw/isaPkg.sv
package isaPkg;

	// Instruction fields
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] funct_t;

	// Primary opcodes
	localparam opcode_t opcodeRInstruction = 6'b000000;
	localparam opcode_t opcodeAddi = 6'b001000;
	localparam opcode_t opcodeAddiu = 6'b001001;
	localparam opcode_t opcodeLui = 6'b001111;

	// Function field, only meaningful under opcodeRInstruction
	localparam funct_t functAdd = 6'b100000;
	localparam funct_t functAnd = 6'b100100;
	localparam funct_t functSub = 6'b100010;
	localparam funct_t functSrl = 6'b000010;
	localparam funct_t functSra = 6'b000011;
	localparam funct_t functXchg = 6'b000101;
	localparam funct_t functBreak = 6'b001101;

	// What the execute state has to do
	typedef enum logic [3:0] {
		classAddi,
		classAddiu,
		classLui,
		classAdd,
		classAnd,
		classSub,
		classSrl,
		classSra,
		classXchg,
		classBreak,
		classUnsupported
	} instrClass_t;

endpackage
